/* design/uart_consts.svh */
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// frame format shared by tx and rx

// data bits per frame, sent lsb first
`define UART_DATA_WIDTH 8

// clocks per bit period
`define UART_CLKS_PER_BIT 8

// 1 adds a parity bit between data and stop
`define UART_PARITY_EN 1

// 0 = even parity, 1 = odd parity
`define UART_PARITY_ODD 0

// rx input synchronizer depth
`define UART_SYNC_STAGES 3

// start + data + parity + stop, 11 with the defaults
`define UART_FRAME_BITS (1 + `UART_DATA_WIDTH + `UART_PARITY_EN + 1)

`endif

/* design/uart_pkg.sv */
`include "uart_consts.svh"

package uart_pkg;

	// one data word
	typedef logic [`UART_DATA_WIDTH-1:0] uart_data_t;

	// counts clocks inside one bit period
	typedef logic [$clog2(`UART_CLKS_PER_BIT)-1:0] baud_cnt_t;

	// transmitter, one state per frame field
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} tx_state_e;

	// receiver, same field order as the line
	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_e;

	// what the host gets at the end of a frame
	typedef struct packed {
		uart_data_t data;
		logic       parity_err; // received parity bit disagrees with data
		logic       frame_err;  // stop bit sampled low
	} rx_result_t;

endpackage

/* design/uart_baud_gen.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_baud_gen import uart_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic i_run,  // high for the whole tx frame
	output logic o_tick  // last clock of each bit period
);

	localparam baud_cnt_t CNT_LAST = baud_cnt_t'(`UART_CLKS_PER_BIT - 1);

	baud_cnt_t cnt_q;

	// held at zero between frames so the first bit is always full length
	always_ff @(posedge clk) begin
		if (reset || !i_run) begin
			cnt_q <= '0;
		end else if (cnt_q == CNT_LAST) begin
			cnt_q <= '0; // wrap at terminal count
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	assign o_tick = i_run && (cnt_q == CNT_LAST);

	// a tick always closes a full period of run, never a partial one
	a_tick_full_period: assert property (
		@(posedge clk) disable iff (reset)
		o_tick |-> i_run && $past(i_run, `UART_CLKS_PER_BIT - 1)
	);

endmodule

/* design/uart_tx.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_tx import uart_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       i_enable, // host request, ignored while busy
	input  uart_data_t i_data,   // captured on accept
	input  logic       i_tick,   // end of current bit
	output logic       o_run,    // keeps the baud counter going
	output logic       o_busy,
	output logic       o_serial
);

	localparam int FRAME = `UART_FRAME_BITS;
	localparam int DW    = `UART_DATA_WIDTH;
	localparam logic [$clog2(DW)-1:0] LAST_BIT = ($clog2(DW))'(DW - 1);

	tx_state_e             state_q;
	logic [FRAME-1:0]      shift_q;    // stop, parity, data, start with start at bit 0
	logic [FRAME-1:0]      frame_load; // frame built from i_data
	logic [$clog2(DW)-1:0] bit_cnt_q;  // data bit index
	logic                  busy_q;
	logic                  accept;

	assign accept = i_enable && !busy_q;

	// start bit 0, data lsb first, parity, stop bit 1
	always_comb begin
		frame_load          = '1;
		frame_load[0]       = 1'b0;
		frame_load[DW:1]    = i_data;
		if (`UART_PARITY_EN != 0) begin
			frame_load[DW+1] = (^i_data) ^ 1'(`UART_PARITY_ODD); // xor of data, flipped for odd
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q   <= TX_IDLE;
			busy_q    <= 1'b0;
			shift_q   <= '1; // line idles high
			bit_cnt_q <= '0;
		end else begin
			if (state_q != TX_IDLE && i_tick) begin
				shift_q <= {1'b1, shift_q[FRAME-1:1]}; // ones fill behind the stop bit
			end
			case (state_q)
				TX_IDLE: begin
					if (accept) begin
						state_q <= TX_START;
						busy_q  <= 1'b1;
						shift_q <= frame_load; // start bit on the line next cycle
					end
				end
				TX_START: begin
					if (i_tick) begin
						state_q   <= TX_DATA;
						bit_cnt_q <= '0;
					end
				end
				TX_DATA: begin
					if (i_tick) begin
						bit_cnt_q <= bit_cnt_q + 1'b1;
						if (bit_cnt_q == LAST_BIT) begin
							state_q <= (`UART_PARITY_EN != 0) ? TX_PARITY : TX_STOP;
						end
					end
				end
				TX_PARITY: begin
					if (i_tick) state_q <= TX_STOP;
				end
				TX_STOP: begin
					if (i_tick) begin
						state_q <= TX_IDLE; // next accept possible right away
						busy_q  <= 1'b0;
					end
				end
				default: state_q <= TX_IDLE;
			endcase
		end
	end

	assign o_run    = (state_q != TX_IDLE);
	assign o_busy   = busy_q;
	assign o_serial = shift_q[0];

	// line must be back at the idle level whenever the host sees not busy
	a_idle_high: assert property (@(posedge clk) disable iff (reset) !o_busy |-> o_serial);

	// busy flop and baud run from the fsm must never drift apart
	a_busy_run: assert property (@(posedge clk) disable iff (reset) o_busy == o_run);

endmodule

/* design/uart_rx.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_rx import uart_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       i_serial, // asynchronous line
	output logic       o_valid,  // one cycle at the stop-bit sample
	output rx_result_t o_result  // held until the next frame ends
);

	localparam int DW   = `UART_DATA_WIDTH;
	localparam int SYNC = `UART_SYNC_STAGES;
	localparam logic [$clog2(DW)-1:0] LAST_BIT = ($clog2(DW))'(DW - 1);

	localparam baud_cnt_t FULL_LAST = baud_cnt_t'(`UART_CLKS_PER_BIT - 1);
	localparam baud_cnt_t HALF_LAST = baud_cnt_t'(`UART_CLKS_PER_BIT / 2 - 1);

	logic [SYNC-1:0]       sync_q;      // bit 0 sees the raw line
	logic                  line;        // synchronized line
	logic                  line_prev_q; // for falling edge detect
	rx_state_e             state_q;
	baud_cnt_t             cnt_q;       // aligned to bit middles
	logic [$clog2(DW)-1:0] bit_cnt_q;
	uart_data_t            data_q;      // shifts in from the top
	logic                  par_bit_q;   // parity bit as received
	logic                  sample;      // middle of the current bit
	logic                  valid_q;
	rx_result_t            result_q;

	// preset high so leaving reset does not look like a start bit
	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q      <= '1;
			line_prev_q <= 1'b1;
		end else begin
			sync_q      <= {sync_q[SYNC-2:0], i_serial};
			line_prev_q <= line;
		end
	end

	assign line = sync_q[SYNC-1];

	// start waits half a bit, every later field a full bit
	assign sample = (state_q == RX_START) ? (cnt_q == HALF_LAST) : (cnt_q == FULL_LAST);

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q             <= RX_IDLE;
			cnt_q               <= '0;
			bit_cnt_q           <= '0;
			valid_q             <= 1'b0;
			result_q.parity_err <= 1'b0;
			result_q.frame_err  <= 1'b0;
		end else begin
			valid_q <= 1'b0; // pulse only
			cnt_q   <= sample ? '0 : cnt_q + 1'b1;
			case (state_q)
				RX_IDLE: begin
					cnt_q <= '0;
					if (line_prev_q && !line) begin
						state_q <= RX_START; // falling edge, maybe a start bit
					end
				end
				RX_START: begin
					if (sample) begin
						bit_cnt_q <= '0;
						// still low at mid start, else it was a glitch
						state_q   <= line ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (sample) begin
						data_q    <= {line, data_q[DW-1:1]}; // lsb arrives first
						bit_cnt_q <= bit_cnt_q + 1'b1;
						if (bit_cnt_q == LAST_BIT) begin
							state_q <= (`UART_PARITY_EN != 0) ? RX_PARITY : RX_STOP;
						end
					end
				end
				RX_PARITY: begin
					if (sample) begin
						par_bit_q <= line;
						state_q   <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (sample) begin
						state_q       <= RX_IDLE; // second half of stop is high, next edge is seen
						valid_q       <= 1'b1;
						result_q.data <= data_q;
						result_q.parity_err <= (`UART_PARITY_EN != 0) &&
							(par_bit_q != ((^data_q) ^ 1'(`UART_PARITY_ODD)));
						result_q.frame_err  <= !line; // stop bit must be 1
					end
				end
				default: state_q <= RX_IDLE;
			endcase
		end
	end

	assign o_valid  = valid_q;
	assign o_result = result_q;

	// a full frame separates two results
	a_valid_pulse: assert property (@(posedge clk) disable iff (reset) o_valid |=> !o_valid);

endmodule

/* design/uart_core.sv */
`timescale 1ns/10ps

module uart_core import uart_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	// transmit host side
	input  logic       i_tx_enable,
	input  uart_data_t i_tx_data,
	output logic       o_tx_busy,
	output logic       o_serial_out,
	// receive side, wired to o_serial_out outside for loopback
	input  logic       i_serial_in,
	output logic       o_rx_valid,
	output rx_result_t o_rx_result
);

	logic bit_run;  // tx frame in progress
	logic bit_tick; // end of a tx bit

	// bit timing for the transmitter only, rx keeps its own counter
	uart_baud_gen baud_gen_i (
		.clk    (clk),
		.reset  (reset),
		.i_run  (bit_run),
		.o_tick (bit_tick)
	);

	uart_tx tx_i (
		.clk      (clk),
		.reset    (reset),
		.i_enable (i_tx_enable),
		.i_data   (i_tx_data),
		.i_tick   (bit_tick),
		.o_run    (bit_run),
		.o_busy   (o_tx_busy),
		.o_serial (o_serial_out)
	);

	uart_rx rx_i (
		.clk      (clk),
		.reset    (reset),
		.i_serial (i_serial_in),
		.o_valid  (o_rx_valid),
		.o_result (o_rx_result)
	);

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	localparam int HALF_PERIOD  = 20; // 40 ns clock
	localparam int RESET_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// released a little after the edge, like every other dut input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 reset = 1'b0;
	end

endmodule

/* tb/tb_uart_core.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

module tb_uart_core import uart_pkg::*; ();

	localparam int   CPB       = `UART_CLKS_PER_BIT;
	localparam int   DW        = `UART_DATA_WIDTH;
	localparam int   FRAME     = `UART_FRAME_BITS;
	localparam int   SYNC      = `UART_SYNC_STAGES;
	localparam int   PAR_EN    = `UART_PARITY_EN;
	localparam logic PAR_ODD   = 1'(`UART_PARITY_ODD);
	localparam int   N_RANDOM  = 16; // loopback frames after the file
	localparam int   DRIVE_DLY = 2;  // ns after the rising edge

	// one line of the pattern file
	typedef struct packed {
		logic       inject;   // set when the tb drives the line, clear for loopback
		uart_data_t data;
		logic       par_flip; // inverts the injected parity bit
		logic       stop_val; // injected stop bit level
		rx_result_t exp_res;
	} frame_t;

	logic       clk;
	logic       reset;
	logic       tx_enable;
	uart_data_t tx_data;
	logic       tx_busy;
	logic       serial_out;
	logic       serial_in;
	logic       rx_valid;
	rx_result_t rx_result;
	logic       loop_mode; // set when serial_out feeds serial_in
	logic       bang_line; // line level for injected frames

	frame_t     frames[$];
	rx_result_t rx_q[$];     // results seen on o_rx_valid
	int         n_frames = 0;

	assign serial_in = loop_mode ? serial_out : bang_line;

	tb_clock_gen clock_gen_i (
		.clk   (clk),
		.reset (reset)
	);

	uart_core dut_i (
		.clk          (clk),
		.reset        (reset),
		.i_tx_enable  (tx_enable),
		.i_tx_data    (tx_data),
		.o_tx_busy    (tx_busy),
		.o_serial_out (serial_out),
		.i_serial_in  (serial_in),
		.o_rx_valid   (rx_valid),
		.o_rx_result  (rx_result)
	);

	// collect every receive pulse away from the rising edge
	always @(negedge clk) begin
		if (!reset && rx_valid) rx_q.push_back(rx_result);
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_data(input string name, input uart_data_t got, input uart_data_t exp);
		if (got !== exp) abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_result(input string name, input rx_result_t got, input rx_result_t exp);
		if (got !== exp) abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
	endtask

	// next rising edge and then the drive offset
	task automatic step();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// line level of bit k where the start bit is k = 0
	function automatic logic frame_bit(input uart_data_t d, input int k,
		input logic flip, input logic stop_val);
		if (k == 0) return 1'b0;
		if (k <= DW) return d[k-1]; // lsb first
		if (PAR_EN != 0 && k == DW + 1) return (^d) ^ PAR_ODD ^ flip;
		return stop_val;
	endfunction

	// waits for a receive pulse and takes exactly one result
	task automatic take_result(input int max_cycles, output rx_result_t r);
		int waited;
		waited = 0;
		while (rx_q.size() == 0 && waited < max_cycles) begin
			step();
			waited++;
		end
		if (rx_q.size() == 0) abort_run($sformatf("no o_rx_valid within %0d cycles", max_cycles));
		if (rx_q.size() != 1) abort_run($sformatf("expected one o_rx_valid, saw %0d", rx_q.size()));
		r = rx_q.pop_front();
	endtask

	task automatic send_loopback(input frame_t f);
		rx_result_t r;
		loop_mode = 1'b1;
		tx_enable = 1'b1;
		tx_data   = f.data;
		step(); // start bit is on the line once the accept edge has passed
		tx_data   = ~f.data; // captured copy must not follow the input
		for (int n = 0; n < FRAME * CPB; n++) begin
			tx_enable = (n == 3 * CPB); // a request while busy must be ignored
			check_bit("o_tx_busy", tx_busy, 1'b1);
			if (n % CPB == CPB / 2) begin
				check_bit($sformatf("o_serial_out bit %0d", n / CPB), serial_out,
					frame_bit(f.data, n / CPB, 1'b0, 1'b1));
			end
			step();
		end
		check_bit("o_tx_busy", tx_busy, 1'b0); // falls after exactly one frame
		take_result(SYNC + CPB, r);
		check_data("o_rx_result.data", r.data, f.exp_res.data);
		check_result("o_rx_result", r, f.exp_res);
		step();
		check_bit("o_tx_busy", tx_busy, 1'b0); // no second frame started
	endtask

	task automatic send_injected(input frame_t f);
		rx_result_t r;
		loop_mode = 1'b0;
		for (int k = 0; k < FRAME; k++) begin
			bang_line = frame_bit(f.data, k, f.par_flip, f.stop_val);
			repeat (CPB) step();
		end
		bang_line = 1'b1;
		take_result(SYNC + CPB, r);
		check_data("o_rx_result.data", r.data, f.exp_res.data);
		check_result("o_rx_result", r, f.exp_res);
		repeat (2 * CPB) step(); // idle gap
		if (rx_q.size() != 0) abort_run("extra o_rx_valid after an injected frame");
		loop_mode = 1'b1;
	endtask

	// columns are mode data par_flip stop exp_data exp_parity_err exp_frame_err
	task automatic load_patterns();
		int          fd;
		int          cnt;
		string       line;
		logic [31:0] col [6];
		frame_t      f;
		fd = $fopen("tb/uart_patterns.txt", "r");
		if (fd == 0) abort_run("cannot open tb/uart_patterns.txt");
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) == 0) break;
			if (line.len() < 2 || (line[0] != "L" && line[0] != "I")) continue; // comment
			cnt = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h %h",
				col[0], col[1], col[2], col[3], col[4], col[5]);
			if (cnt != 6) abort_run({"malformed pattern line: ", line});
			f.inject             = (line[0] == "I");
			f.data               = col[0][DW-1:0];
			f.par_flip           = col[1][0];
			f.stop_val           = col[2][0];
			f.exp_res.data       = col[3][DW-1:0];
			f.exp_res.parity_err = col[4][0];
			f.exp_res.frame_err  = col[5][0];
			frames.push_back(f);
		end
		$fclose(fd);
	endtask

	initial begin
		frame_t f;
		tx_enable = 1'b0;
		tx_data   = '0;
		loop_mode = 1'b1;
		bang_line = 1'b1; // idle line
		void'($urandom(32'h5da4));
		load_patterns();
		n_frames = frames.size() + N_RANDOM;
		@(negedge reset);
		step();
		check_bit("o_serial_out", serial_out, 1'b1);
		check_bit("o_tx_busy", tx_busy, 1'b0);
		check_bit("o_rx_valid", rx_valid, 1'b0);
		check_bit("o_rx_result.parity_err", rx_result.parity_err, 1'b0);
		check_bit("o_rx_result.frame_err", rx_result.frame_err, 1'b0);
		foreach (frames[i]) begin
			if (frames[i].inject) send_injected(frames[i]);
			else send_loopback(frames[i]);
		end
		repeat (N_RANDOM) begin
			f              = '0;
			f.data         = uart_data_t'($urandom);
			f.stop_val     = 1'b1;
			f.exp_res.data = f.data; // loopback returns the word with both flags clear
			send_loopback(f);
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

	// twice the length of all frames plus slack for reset and gaps
	initial begin
		wait (n_frames != 0);
		repeat ((n_frames + 4) * FRAME * CPB * 2) @(posedge clk);
		abort_run("watchdog expired, the run hung");
	end

endmodule

/* uart_core.f */
+incdir+design
design/uart_pkg.sv
design/uart_baud_gen.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_core.sv
tb/tb_clock_gen.sv
tb/tb_uart_core.sv

/* Makefile */
# Verilator build and run for the UART core testbench

VERILATOR ?= verilator
TOP       ?= tb_uart_core
FILELIST  ?= uart_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: sim clean

# build, run, and succeed only when the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* tb/uart_patterns.txt */
# mode data par_flip stop exp_data exp_parity_err exp_frame_err (hex)
# L = loopback through the transmitter, I = frame driven onto i_serial_in
L 00 0 1 00 0 0
L ff 0 1 ff 0 0
L a5 0 1 a5 0 0
L 5a 0 1 5a 0 0
L 01 0 1 01 0 0
L 80 0 1 80 0 0
I 55 0 1 55 0 0
I 55 1 1 55 1 0
I c3 1 1 c3 1 0
I 00 1 1 00 1 0
I 0f 0 0 0f 0 1
I f0 1 0 f0 1 1
I 81 0 0 81 0 1
I 7e 0 1 7e 0 0
L 3c 0 1 3c 0 0
L e7 0 1 e7 0 0
L 96 0 1 96 0 0
L 6d 0 1 6d 0 0
